// ==== icache_pkg.sv ====
package icache_pkg;

	// ========================================================================
	// Cache geometry
	// ========================================================================

	localparam int ADDR_W     = 32;
	localparam int LINE_BYTES = 16;
	localparam int OFS_W      = 4;
	localparam int NUM_BANKS  = 2;
	localparam int SETS       = 16;
	localparam int SET_W      = 4;
	localparam int WAYS       = 2;
	localparam int WAY_W      = 1;
	localparam int LINE_W     = 128;
	localparam int TAG_W      = 23;

	// Address layout from the low bits up is offset, bank bit, set and tag
	localparam int BANK_LSB = OFS_W;
	localparam int SET_LSB  = OFS_W + 1;
	localparam int TAG_LSB  = OFS_W + 1 + SET_W;
	// Width of a line number, which is the address without its offset
	localparam int LNUM_W   = ADDR_W - OFS_W;

	typedef enum logic [1:0] {
		INV_NONE,
		INV_LINE,
		INV_ALL
	} inv_op_e;

	typedef logic [ADDR_W-1:0] fill_addr_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [TAG_W-1:0]  tag_t;

	// The bank bit is the parity of the line number
	function automatic logic addr_bank(input fill_addr_t a);
		return a[BANK_LSB];
	endfunction

	function automatic logic [SET_W-1:0] addr_set(input fill_addr_t a);
		return a[SET_LSB +: SET_W];
	endfunction

	function automatic tag_t addr_tag(input fill_addr_t a);
		return a[TAG_LSB +: TAG_W];
	endfunction

endpackage

// ==== icache_bank_if.sv ====
`timescale 1ns/1ps

// Everything the feeder sends to one bank
interface icache_bank_req_if import icache_pkg::*; ();
	// Pipeline advance, common to every stage
	logic             adv;
	// Lookup of the line of the fetch pair that this bank owns
	logic             look_v;
	logic [SET_W-1:0] look_set;
	tag_t             look_tag;
	// Refill write port, the way is picked by the refill source
	logic             fill_en;
	logic [SET_W-1:0] fill_set;
	tag_t             fill_tag;
	logic [WAY_W-1:0] fill_way;
	line_t            fill_data;
	// Invalidation, INV_NONE when this bank is not addressed
	inv_op_e          inv_op;
	logic [SET_W-1:0] inv_set;
	tag_t             inv_tag;
	// Snoop
	logic             snoop_en;
	logic [SET_W-1:0] snoop_set;
	tag_t             snoop_tag;

	modport feeder (output adv, look_v, look_set, look_tag, fill_en, fill_set, fill_tag,
		fill_way, fill_data, inv_op, inv_set, inv_tag, snoop_en, snoop_set, snoop_tag);
	modport bank (input adv, look_v, look_set, look_tag, fill_en, fill_set, fill_tag,
		fill_way, fill_data, inv_op, inv_set, inv_tag, snoop_en, snoop_set, snoop_tag);
endinterface

// Registered lookup result of one bank
interface icache_bank_rsp_if import icache_pkg::*; ();
	logic  hit;
	line_t data;

	modport bank (output hit, data);
	modport aligner (input hit, data);
endinterface

// ==== icache_feeder.sv ====
`timescale 1ns/1ps

module icache_feeder import icache_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 req_valid_i,
	input  fill_addr_t           req_addr_i,
	input  logic                 adv_i,
	output logic                 req_ready_o,
	input  logic                 fill_valid_i,
	input  fill_addr_t           fill_addr_i,
	input  logic [WAY_W-1:0]     fill_way_i,
	input  line_t                fill_data_i,
	input  inv_op_e              inv_op_i,
	input  fill_addr_t           inv_addr_i,
	input  logic                 snoop_valid_i,
	input  fill_addr_t           snoop_addr_i,
	icache_bank_req_if.feeder    req_if [NUM_BANKS],
	output fill_addr_t           out_addr_o
);

	logic              stage_v;
	fill_addr_t        stage_addr;
	logic [LNUM_W-1:0] fetch_line;
	logic [LNUM_W-1:0] next_line;
	// Line of the pair held by each bank, index 0 is even
	logic [LNUM_W-1:0] pair_line [NUM_BANKS];

	// The whole pipeline moves on one advance, so a request is taken
	// exactly when every stage is free to shift
	assign req_ready_o = adv_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_v <= 1'b0;
		end else if (adv_i) begin
			stage_v <= req_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (adv_i) begin
			stage_addr <= req_addr_i;
		end
	end

	assign out_addr_o = stage_addr;

	// ========================================================================
	// Line pair
	// ========================================================================

	assign fetch_line = stage_addr[ADDR_W-1:OFS_W];
	assign next_line  = fetch_line + 1'b1;

	// An odd fetch line pairs with the even line after it
	assign pair_line[0] = fetch_line[0] ? next_line : fetch_line;
	assign pair_line[1] = fetch_line[0] ? fetch_line : next_line;

	// ========================================================================
	// Per-bank request
	// ========================================================================

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_route
		assign req_if[b].adv      = adv_i;
		assign req_if[b].look_v   = stage_v;
		assign req_if[b].look_set = addr_set({pair_line[b], {OFS_W{1'b0}}});
		assign req_if[b].look_tag = addr_tag({pair_line[b], {OFS_W{1'b0}}});

		// Only the bank that owns the line parity sees the refill
		assign req_if[b].fill_en   = fill_valid_i && (addr_bank(fill_addr_i) == 1'(b));
		assign req_if[b].fill_set  = addr_set(fill_addr_i);
		assign req_if[b].fill_tag  = addr_tag(fill_addr_i);
		assign req_if[b].fill_way  = fill_way_i;
		assign req_if[b].fill_data = fill_data_i;

		// INV_ALL reaches both banks, INV_LINE only the owner
		assign req_if[b].inv_op  = (inv_op_i == INV_ALL || addr_bank(inv_addr_i) == 1'(b)) ?
			inv_op_i : INV_NONE;
		assign req_if[b].inv_set = addr_set(inv_addr_i);
		assign req_if[b].inv_tag = addr_tag(inv_addr_i);

		assign req_if[b].snoop_en  = snoop_valid_i && (addr_bank(snoop_addr_i) == 1'(b));
		assign req_if[b].snoop_set = addr_set(snoop_addr_i);
		assign req_if[b].snoop_tag = addr_tag(snoop_addr_i);
	end

endmodule

// ==== icache_bank.sv ====
`timescale 1ns/1ps

module icache_bank import icache_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	icache_bank_req_if.bank   req,
	icache_bank_rsp_if.bank   rsp,
	input  fill_addr_t        stg_addr_i,
	output logic              stg_v_o,
	output fill_addr_t        stg_addr_o
);

	// ========================================================================
	// Storage
	// ========================================================================

	tag_t             tag_mem  [WAYS][SETS];
	line_t            data_mem [WAYS][SETS];
	logic [SETS-1:0]  valid_q  [WAYS];

	// Lookup compare of the current set
	logic             look_hit;
	logic [WAY_W-1:0] look_way;

	// Maintenance tag compare, one bit per way
	logic [WAYS-1:0]  inv_match;
	logic [WAYS-1:0]  snoop_match;

	// Stage register
	logic             hit_q;
	line_t            data_q;
	logic             stg_v_q;
	fill_addr_t       stg_addr_q;

	// ========================================================================
	// Lookup
	// ========================================================================

	// The arrays are read before this edge's updates land, so a fill or a
	// clear presented on the same edge is not seen by the lookup
	always_comb begin
		look_hit = 1'b0;
		look_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid_q[w][req.look_set] && tag_mem[w][req.look_set] == req.look_tag) begin
				look_hit = 1'b1;
				look_way = WAY_W'(w);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q   <= 1'b0;
			stg_v_q <= 1'b0;
		end else if (req.adv) begin
			hit_q   <= req.look_v && look_hit;
			stg_v_q <= req.look_v;
		end
	end

	always_ff @(posedge clk) begin
		if (req.adv) begin
			data_q     <= data_mem[look_way][req.look_set];
			stg_addr_q <= stg_addr_i;
		end
	end

	assign rsp.hit    = hit_q;
	assign rsp.data   = data_q;
	assign stg_v_o    = stg_v_q;
	assign stg_addr_o = stg_addr_q;

	// ========================================================================
	// Maintenance
	// ========================================================================

	// Compare against the tag each way will hold after this edge's fill
	// so that a clear of a line being filled right now still hits it
	always_comb begin
		tag_t inv_tag_w;
		tag_t snoop_tag_w;
		for (int w = 0; w < WAYS; w++) begin
			inv_tag_w   = tag_mem[w][req.inv_set];
			snoop_tag_w = tag_mem[w][req.snoop_set];
			if (req.fill_en && req.fill_way == WAY_W'(w)) begin
				if (req.fill_set == req.inv_set)
					inv_tag_w = req.fill_tag;
				if (req.fill_set == req.snoop_set)
					snoop_tag_w = req.fill_tag;
			end
			inv_match[w]   = (inv_tag_w == req.inv_tag);
			snoop_match[w] = req.snoop_en && (snoop_tag_w == req.snoop_tag);
		end
	end

	// Later assignments override earlier ones in the block, which gives
	// the fill, invalidate, snoop priority with a clear beating a fill
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++)
				valid_q[w] <= '0;
		end else begin
			if (req.fill_en)
				valid_q[req.fill_way][req.fill_set] <= 1'b1;
			for (int w = 0; w < WAYS; w++) begin
				if (req.inv_op == INV_ALL)
					valid_q[w] <= '0;
				else if (req.inv_op == INV_LINE && inv_match[w])
					valid_q[w][req.inv_set] <= 1'b0;
				if (snoop_match[w])
					valid_q[w][req.snoop_set] <= 1'b0;
			end
		end
	end

	// Tag and data arrays only change on a refill
	always_ff @(posedge clk) begin
		if (req.fill_en) begin
			tag_mem[req.fill_way][req.fill_set]  <= req.fill_tag;
			data_mem[req.fill_way][req.fill_set] <= req.fill_data;
		end
	end

endmodule

// ==== icache_aligner.sv ====
`timescale 1ns/1ps

module icache_aligner import icache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	icache_bank_rsp_if.aligner    rsp [NUM_BANKS],
	input  logic                  stg_v_i,
	input  fill_addr_t            stg_addr_i,
	input  logic                  rsp_ready_i,
	output logic                  rsp_valid_o,
	output fill_addr_t            rsp_addr_o,
	output logic                  rsp_hit_o,
	output line_t                 rsp_line_lo_o,
	output line_t                 rsp_line_hi_o,
	output logic                  rsp_lo_hit_o,
	output logic                  rsp_hi_hit_o,
	output fill_addr_t            rsp_miss_addr_o,
	output logic                  adv_o
);

	logic       odd_fetch;
	line_t      line_lo;
	line_t      line_hi;
	logic       lo_hit;
	logic       hi_hit;
	fill_addr_t lo_base;
	fill_addr_t hi_base;
	fill_addr_t miss_addr;

	// Every stage shifts when the output register is empty or being drained
	assign adv_o = !rsp_valid_o || rsp_ready_i;

	// An odd fetch line lives in bank 1 and its next line in bank 0
	assign odd_fetch = addr_bank(stg_addr_i);
	assign line_lo   = odd_fetch ? rsp[1].data : rsp[0].data;
	assign line_hi   = odd_fetch ? rsp[0].data : rsp[1].data;
	assign lo_hit    = odd_fetch ? rsp[1].hit  : rsp[0].hit;
	assign hi_hit    = odd_fetch ? rsp[0].hit  : rsp[1].hit;

	assign lo_base = {stg_addr_i[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
	assign hi_base = lo_base + ADDR_W'(LINE_BYTES);

	// The low line is reported first since it is needed first
	assign miss_addr = !lo_hit ? lo_base : (!hi_hit ? hi_base : '0);

	// ========================================================================
	// Output register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid_o <= 1'b0;
		end else if (adv_o) begin
			rsp_valid_o <= stg_v_i;
		end
	end

	// Held while stalled so the response stays stable
	always_ff @(posedge clk) begin
		if (adv_o) begin
			rsp_addr_o      <= stg_addr_i;
			rsp_line_lo_o   <= line_lo;
			rsp_line_hi_o   <= line_hi;
			rsp_lo_hit_o    <= lo_hit;
			rsp_hi_hit_o    <= hi_hit;
			rsp_hit_o       <= lo_hit && hi_hit;
			rsp_miss_addr_o <= miss_addr;
		end
	end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	// Fetch request
	input  logic             req_valid_i,
	input  fill_addr_t       req_addr_i,
	output logic             req_ready_o,
	// Fetch response
	output logic             rsp_valid_o,
	input  logic             rsp_ready_i,
	output fill_addr_t       rsp_addr_o,
	output logic             rsp_hit_o,
	output line_t            rsp_line_lo_o,
	output line_t            rsp_line_hi_o,
	output logic             rsp_lo_hit_o,
	output logic             rsp_hi_hit_o,
	output fill_addr_t       rsp_miss_addr_o,
	// Maintenance strobes, always accepted
	input  logic             fill_valid_i,
	input  fill_addr_t       fill_addr_i,
	input  logic [WAY_W-1:0] fill_way_i,
	input  line_t            fill_data_i,
	input  inv_op_e          inv_op_i,
	input  fill_addr_t       inv_addr_i,
	input  logic             snoop_valid_i,
	input  fill_addr_t       snoop_addr_i
);

	icache_bank_req_if req_if [NUM_BANKS] ();
	icache_bank_rsp_if rsp_if [NUM_BANKS] ();

	logic                 adv;
	fill_addr_t           feed_addr;
	logic [NUM_BANKS-1:0] bank_v;
	fill_addr_t           bank_addr [NUM_BANKS];

	icache_feeder i_feeder (
		.clk           (clk),
		.rst           (rst),
		.req_valid_i   (req_valid_i),
		.req_addr_i    (req_addr_i),
		.adv_i         (adv),
		.req_ready_o   (req_ready_o),
		.fill_valid_i  (fill_valid_i),
		.fill_addr_i   (fill_addr_i),
		.fill_way_i    (fill_way_i),
		.fill_data_i   (fill_data_i),
		.inv_op_i      (inv_op_i),
		.inv_addr_i    (inv_addr_i),
		.snoop_valid_i (snoop_valid_i),
		.snoop_addr_i  (snoop_addr_i),
		.req_if        (req_if),
		.out_addr_o    (feed_addr)
	);

	// Bank 0 holds even lines and bank 1 odd lines
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		icache_bank i_bank (
			.clk        (clk),
			.rst        (rst),
			.req        (req_if[b]),
			.rsp        (rsp_if[b]),
			.stg_addr_i (feed_addr),
			.stg_v_o    (bank_v[b]),
			.stg_addr_o (bank_addr[b])
		);
	end

	// Both banks shift on the same advance, so their stage copies agree
	icache_aligner i_aligner (
		.clk             (clk),
		.rst             (rst),
		.rsp             (rsp_if),
		.stg_v_i         (&bank_v),
		.stg_addr_i      (bank_addr[0]),
		.rsp_ready_i     (rsp_ready_i),
		.rsp_valid_o     (rsp_valid_o),
		.rsp_addr_o      (rsp_addr_o),
		.rsp_hit_o       (rsp_hit_o),
		.rsp_line_lo_o   (rsp_line_lo_o),
		.rsp_line_hi_o   (rsp_line_hi_o),
		.rsp_lo_hit_o    (rsp_lo_hit_o),
		.rsp_hi_hit_o    (rsp_hi_hit_o),
		.rsp_miss_addr_o (rsp_miss_addr_o),
		.adv_o           (adv)
	);

endmodule

// ==== icache_checker.sv ====
`timescale 1ns/1ps

module icache_checker import icache_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       req_valid_i,
	input logic       req_ready_o,
	input logic       rsp_valid_o,
	input logic       rsp_ready_i,
	input fill_addr_t rsp_addr_o,
	input logic       rsp_hit_o,
	input line_t      rsp_line_lo_o,
	input line_t      rsp_line_hi_o,
	input fill_addr_t rsp_miss_addr_o
);

	// Requests accepted but not yet handed out
	int in_flight;

	always_ff @(posedge clk) begin
		if (rst)
			in_flight <= 0;
		else
			in_flight <= in_flight + int'(req_valid_i && req_ready_o)
				- int'(rsp_valid_o && rsp_ready_i);
	end

	// A stalled response keeps its valid and its payload
	a_stall_stable: assert property (@(posedge clk) disable iff (rst)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_addr_o)
		&& $stable(rsp_hit_o) && $stable(rsp_line_lo_o) && $stable(rsp_line_hi_o)
		&& $stable(rsp_miss_addr_o))
		else $error("stalled response changed");

	a_reset_idle: assert property (@(posedge clk) rst |=> !rsp_valid_o)
		else $error("response valid during reset");

	// Three stages hold at most three requests, and none vanish
	a_no_loss: assert property (@(posedge clk) disable iff (rst)
		in_flight >= 0 && in_flight <= 3)
		else $error("in-flight request count out of range");

endmodule

bind icache_top icache_checker i_checker (
	.clk             (clk),
	.rst             (rst),
	.req_valid_i     (req_valid_i),
	.req_ready_o     (req_ready_o),
	.rsp_valid_o     (rsp_valid_o),
	.rsp_ready_i     (rsp_ready_i),
	.rsp_addr_o      (rsp_addr_o),
	.rsp_hit_o       (rsp_hit_o),
	.rsp_line_lo_o   (rsp_line_lo_o),
	.rsp_line_hi_o   (rsp_line_hi_o),
	.rsp_miss_addr_o (rsp_miss_addr_o)
);

// ==== tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

	// Fetches, fills and maintenance cycles of all tests, plus drains
	localparam int STIM_CYCLES = 5 + 64 + 128 + 200 + 64 + 64 + 328 + 300 + 100 + 7 * 10;
	localparam int LIMIT       = 4 * STIM_CYCLES + 200;

	typedef struct {
		fill_addr_t addr;
		logic       lo_hit;
		logic       hi_hit;
		line_t      lo;
		line_t      hi;
		int         cyc;
	} exp_t;

	logic clk = 0;
	logic rst = 1;
	logic req_valid_i = 0, rsp_ready_i = 0, fill_valid_i = 0, snoop_valid_i = 0;
	fill_addr_t req_addr_i = '0, fill_addr_i = '0, inv_addr_i = '0, snoop_addr_i = '0;
	logic [WAY_W-1:0] fill_way_i = '0;
	line_t fill_data_i = '0;
	inv_op_e inv_op_i = INV_NONE;
	logic req_ready_o, rsp_valid_o, rsp_hit_o, rsp_lo_hit_o, rsp_hi_hit_o;
	fill_addr_t rsp_addr_o, rsp_miss_addr_o;
	line_t rsp_line_lo_o, rsp_line_hi_o;

	// Model of both banks, indexed bank, way, set
	logic m_val [2][WAYS][SETS];
	tag_t m_tag [2][WAYS][SETS];
	line_t m_data [2][WAYS][SETS];
	logic m_feed_v, m_bank_v, m_out_v;
	fill_addr_t m_feed_addr;
	int m_feed_cyc;
	exp_t exp_q [$];
	logic [LNUM_W-1:0] pool [64];
	int cycles = 0, checks = 0, errors = 0, test_err;
	logic check_lat = 0;

	icache_top i_dut (.*);

	always #2 clk = ~clk;

	task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// A line number holds the bank in bit 0, then the set, then the tag
	function automatic void lookup(input logic [LNUM_W-1:0] ln, output logic hit,
			output line_t d);
		hit = 0;
		d = '0;
		for (int w = 0; w < WAYS; w++)
			if (m_val[ln[0]][w][ln[SET_W:1]] &&
					m_tag[ln[0]][w][ln[SET_W:1]] == ln[LNUM_W-1:SET_W+1]) begin
				hit = 1;
				d = m_data[ln[0]][w][ln[SET_W:1]];
			end
	endfunction

	// Clears every way of the set whose tag matches the line
	function automatic void clear_line(input logic [LNUM_W-1:0] ln);
		for (int w = 0; w < WAYS; w++)
			if (m_tag[ln[0]][w][ln[SET_W:1]] == ln[LNUM_W-1:SET_W+1])
				m_val[ln[0]][w][ln[SET_W:1]] = 0;
	endfunction

	// ========================================================================
	// Reference model and response checks, sampled on every rising edge
	// ========================================================================

	always @(posedge clk) begin
		exp_t e;
		logic adv;
		logic [LNUM_W-1:0] fl;
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Done: errors found");
			$finish;
		end else if (rst) begin
			m_feed_v = 0;
			m_bank_v = 0;
			m_out_v = 0;
			exp_q.delete();
			foreach (m_val[b, w, s]) m_val[b][w][s] = 0;
		end else begin
			adv = !m_out_v || rsp_ready_i;
			check_val("rsp_valid_o", rsp_valid_o, m_out_v);
			check_val("req_ready_o", req_ready_o, adv);
			if (rsp_valid_o && rsp_ready_i) begin
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("Response at %0t with no request outstanding", $time);
				end
				if (exp_q.size() != 0) begin
					e = exp_q.pop_front();
					check_val("rsp_addr_o", rsp_addr_o, e.addr);
					check_val("rsp_lo_hit_o", rsp_lo_hit_o, e.lo_hit);
					check_val("rsp_hi_hit_o", rsp_hi_hit_o, e.hi_hit);
					check_val("rsp_hit_o", rsp_hit_o, e.lo_hit && e.hi_hit);
					if (e.lo_hit) check_val("rsp_line_lo_o", rsp_line_lo_o, e.lo);
					if (e.hi_hit) check_val("rsp_line_hi_o", rsp_line_hi_o, e.hi);
					check_val("rsp_miss_addr_o", rsp_miss_addr_o,
						!e.lo_hit ? {e.addr[31:4], 4'h0} :
						!e.hi_hit ? {e.addr[31:4], 4'h0} + 32'd16 : 32'd0);
					if (check_lat) check_val("response latency", cycles - e.cyc, 3);
				end
			end
			if (adv) begin
				// The lookup sees the arrays before this edge's maintenance
				if (m_feed_v) begin
					e.addr = m_feed_addr;
					e.cyc = m_feed_cyc;
					lookup(m_feed_addr[31:4], e.lo_hit, e.lo);
					lookup(m_feed_addr[31:4] + 1'b1, e.hi_hit, e.hi);
					exp_q.push_back(e);
				end
				m_out_v = m_bank_v;
				m_bank_v = m_feed_v;
				m_feed_v = req_valid_i;
				m_feed_addr = req_addr_i;
				m_feed_cyc = cycles;
			end
			if (fill_valid_i) begin
				fl = fill_addr_i[31:4];
				m_val[fl[0]][fill_way_i][fl[SET_W:1]] = 1;
				m_tag[fl[0]][fill_way_i][fl[SET_W:1]] = fl[LNUM_W-1:SET_W+1];
				m_data[fl[0]][fill_way_i][fl[SET_W:1]] = fill_data_i;
			end
			if (inv_op_i == INV_ALL)
				foreach (m_val[b, w, s]) m_val[b][w][s] = 0;
			else if (inv_op_i == INV_LINE)
				clear_line(inv_addr_i[31:4]);
			if (snoop_valid_i)
				clear_line(snoop_addr_i[31:4]);
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	// One maintenance cycle; the way is a fixed function of the line
	task automatic maint(logic fv, logic [LNUM_W-1:0] fl, inv_op_e op, logic [LNUM_W-1:0] il,
			logic sv, logic [LNUM_W-1:0] sl);
		fill_valid_i <= fv;
		fill_addr_i <= {fl, 4'h0};
		fill_way_i <= ^fl[LNUM_W-1:SET_W+1];
		fill_data_i <= {$urandom, $urandom, $urandom, $urandom};
		inv_op_i <= op;
		inv_addr_i <= {il, 4'h0};
		snoop_valid_i <= sv;
		snoop_addr_i <= {sl, 4'h0};
		@(posedge clk);
		fill_valid_i <= 0;
		inv_op_i <= INV_NONE;
		snoop_valid_i <= 0;
	endtask

	task automatic run_fetches(int n, int stall_pct);
		int sent = 0;
		req_valid_i <= 1;
		req_addr_i <= {pool[$urandom % 64], 4'($urandom)};
		rsp_ready_i <= ($urandom % 100) >= stall_pct;
		while (sent < n) begin
			@(posedge clk);
			if (req_ready_o) begin
				sent++;
				if (sent < n) req_addr_i <= {pool[$urandom % 64], 4'($urandom)};
				else req_valid_i <= 0;
			end
			rsp_ready_i <= ($urandom % 100) >= stall_pct;
		end
		rsp_ready_i <= 1;
		while (m_feed_v || m_bank_v || m_out_v || exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic report(string name);
		$display("test %s: %0d errors", name, errors - test_err);
		test_err = errors;
	endtask

	initial begin
		logic [LNUM_W-1:0] ln;
		void'($urandom(32'h25d7_a2b5));
		foreach (pool[i]) pool[i] = LNUM_W'($urandom);
		test_err = 0;
		repeat (5) @(posedge clk);
		rst <= 0;
		@(posedge clk);
		run_fetches(64, 0);
		report("cold misses");
		foreach (pool[i]) begin
			maint(1, pool[i], INV_NONE, 0, 0, 0);
			maint(1, pool[i] + 1'b1, INV_NONE, 0, 0, 0);
		end
		run_fetches(200, 0);
		report("line pair after fill");
		// The next line is refilled and invalidated on the same edge
		for (int i = 0; i < 32; i++) begin
			maint(1, pool[i], INV_NONE, 0, 0, 0);
			maint(1, pool[i] + 1'b1, INV_LINE, pool[i] + 1'b1, 0, 0);
		end
		run_fetches(64, 0);
		report("next line missing");
		for (int i = 0; i < 200; i++) begin
			ln = pool[$urandom % 64] + LNUM_W'($urandom % 2);
			maint($urandom % 2, ln, ($urandom % 50 == 0) ? INV_ALL :
				($urandom % 5 == 0) ? INV_LINE : INV_NONE,
				($urandom % 3 == 0) ? ln : pool[$urandom % 64], $urandom % 5 == 0,
				($urandom % 3 == 0) ? ln : pool[$urandom % 64] + 1'b1);
		end
		run_fetches(128, 0);
		report("invalidate and snoop");
		run_fetches(300, 30);
		report("random stalls");
		check_lat = 1;
		run_fetches(100, 0);
		check_lat = 0;
		report("latency");
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== project.f ====
icache_pkg.sv
icache_bank_if.sv
icache_feeder.sv
icache_bank.sv
icache_aligner.sv
icache_top.sv
icache_checker.sv
tb_icache.sv
